// File: isa_pkg.sv
package isa_pkg;

   //////////////////////////////////////////////////////////////////////////////
   // Instruction fields
   //////////////////////////////////////////////////////////////////////////////

   localparam int WORD_W     = 16;
   localparam int REG_IDX_W  = 3;
   localparam int OPCODE_W   = 5;
   localparam int OPCODE_MSB = 15;
   localparam int OPCODE_LSB = 11;
   // Store source register
   localparam int SRC_MSB    = 7;
   localparam int SRC_LSB    = 5;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // Only the opcodes the memory stage cares about, the rest pass through
   typedef enum logic [OPCODE_W-1:0] {
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_SLBI = 5'b10010,
      OP_STU  = 5'b10011
   } opcode_e;

   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_LOAD,
      MEM_STORE
   } mem_op_e;

   // SLBI shares the 100xx prefix but never touches memory
   function automatic mem_op_e decode_mem_op(opcode_e op);
      mem_op_e cls;
      case (op)
         OP_LD:         cls = MEM_LOAD;
         OP_ST, OP_STU: cls = MEM_STORE;
         default:       cls = MEM_NONE;
      endcase
      return cls;
   endfunction

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

   import isa_pkg::*;

   //////////////////////////////////////////////////////////////////////////////
   // Pipeline bundles around the memory stage
   //////////////////////////////////////////////////////////////////////////////

   // Execute to memory, 65 bits
   typedef struct packed {
      word_t instruction;
      word_t incr_pc;
      // Execute result, also the memory address
      word_t xcomp;
      // Register file value of the store source
      word_t store_data;
      logic  reg_wrt;
   } xm_bundle_t;

   // Memory to writeback, 65 bits
   typedef struct packed {
      word_t instruction;
      word_t incr_pc;
      word_t xcomp;
      // Zero unless the op was a load
      word_t read_data;
      logic  reg_wrt;
   } mw_bundle_t;

   // Register file write from writeback, 20 bits
   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
   } wb_write_t;

endpackage

// File: mem_ctrl_fsm.sv
`timescale 1ns/1ns

module mem_ctrl_fsm import isa_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    in_valid,
   input  logic    out_ready,
   input  opcode_e in_opcode,
   input  logic    timer_done,
   input  logic    result_full,
   output logic    in_ready,
   output logic    load_en,
   output logic    timer_start,
   output logic    mem_en,
   output logic    mem_wr,
   output logic    result_load,
   output mem_op_e mem_op
);

   typedef enum logic [1:0] {
      IDLE,
      WAIT_MEM,
      ACCESS,
      RESULT
   } state_e;

   state_e  state;
   state_e  state_d;
   mem_op_e op_dec;
   mem_op_e op_q;
   logic    ready_q;
   logic    accept;

   assign op_dec = decode_mem_op(in_opcode);
   assign accept = in_valid && ready_q;

   //////////////////////////////////////////////////////////////////////////////
   // Next state
   //////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state;
      case (state)
         IDLE: begin
            if (accept) begin
               state_d = (op_dec == MEM_NONE) ? RESULT : WAIT_MEM;
            end
         end
         WAIT_MEM: begin
            if (timer_done) begin
               state_d = ACCESS;
            end
         end
         ACCESS: state_d = RESULT;
         // Leave once the output handshake empties the register
         RESULT: begin
            if (result_full && out_ready) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= IDLE;
         op_q    <= MEM_NONE;
         ready_q <= 1'b0;
      end else begin
         state   <= state_d;
         // Ready only while sitting in IDLE, never in the reset cycle
         ready_q <= (state_d == IDLE);
         if (accept) begin
            op_q <= op_dec;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////////////
   // Control outputs
   //////////////////////////////////////////////////////////////////////////////

   assign in_ready    = ready_q;
   assign load_en     = accept;
   assign timer_start = accept && (op_dec != MEM_NONE);
   assign mem_en      = (state == ACCESS);
   assign mem_wr      = (state == ACCESS) && (op_q == MEM_STORE);
   // One pulse, the register is empty on entry to RESULT
   assign result_load = (state == RESULT) && !result_full;
   assign mem_op      = op_q;

endmodule

// File: mem_wait_timer.sv
`timescale 1ns/1ns

module mem_wait_timer #(
   parameter int MEM_LATENCY = 3
) (
   input  logic clk,
   input  logic arst_n,
   input  logic start,
   output logic done
);

   localparam int CNT_W = $clog2(MEM_LATENCY + 1);
   // Done shows in the last wait cycle, so count from latency minus one
   localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(MEM_LATENCY - 1);

   logic [CNT_W-1:0] count;
   logic             busy;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
         busy  <= 1'b0;
      end else if (busy) begin
         if (count == '0) begin
            busy <= 1'b0;
         end else begin
            count <= count - 1'b1;
         end
      end else if (start) begin
         busy  <= 1'b1;
         count <= LOAD_VAL;
      end
   end

   assign done = busy && (count == '0);

endmodule

// File: store_fwd_unit.sv
`timescale 1ns/1ns

module store_fwd_unit import isa_pkg::*, pipe_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  wb_write_t wb_write,
   input  reg_idx_t  src_reg,
   input  word_t     rf_data,
   output word_t     store_word
);

   //////////////////////////////////////////////////////////////////////////////
   // Writeback history, two deep
   //////////////////////////////////////////////////////////////////////////////

   wb_write_t hist_new;
   wb_write_t hist_old;
   logic      hit_new;
   logic      hit_old;

   // Shifts only on a real write, idle cycles keep the history
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hist_new <= '0;
         hist_old <= '0;
      end else if (wb_write.valid) begin
         hist_old <= hist_new;
         hist_new <= wb_write;
      end
   end

   //////////////////////////////////////////////////////////////////////////////
   // Store data select
   //////////////////////////////////////////////////////////////////////////////

   assign hit_new = hist_new.valid && (hist_new.rd == src_reg);
   assign hit_old = hist_old.valid && (hist_old.rd == src_reg);

   // Newest match wins
   always_comb begin
      if (hit_new) begin
         store_word = hist_new.data;
      end else if (hit_old) begin
         store_word = hist_old.data;
      end else begin
         store_word = rf_data;
      end
   end

endmodule

// File: data_mem.sv
`timescale 1ns/1ns

module data_mem import isa_pkg::*; #(
   parameter int ADDR_BITS = 8
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 en,
   input  logic                 wr,
   input  logic [ADDR_BITS-1:0] addr,
   input  word_t                wdata,
   output word_t                rdata
);

   localparam int DEPTH = 2 ** ADDR_BITS;

   word_t mem [DEPTH];

   // Word array
   always_ff @(posedge clk) begin
      if (en && wr) begin
         mem[addr] <= wdata;
      end
   end

   // Registered read port, holds between reads
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata <= '0;
      end else if (en && !wr) begin
         rdata <= mem[addr];
      end
   end

endmodule

// File: mem_result_reg.sv
`timescale 1ns/1ns

module mem_result_reg import isa_pkg::*, pipe_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       load_en,
   input  xm_bundle_t in_bundle,
   input  word_t      store_word,
   input  logic       result_load,
   input  word_t      read_data,
   input  logic       out_ready,
   output xm_bundle_t latched,
   output mw_bundle_t out_bundle,
   output logic       out_valid,
   output logic       result_full
);

   logic full;
   logic is_load;

   // Input latch, store data replaced by the forwarded word
   always_ff @(posedge clk) begin
      if (load_en) begin
         latched            <= in_bundle;
         latched.store_data <= store_word;
      end
   end

   assign is_load = decode_mem_op(opcode_e'(latched.instruction[OPCODE_MSB:OPCODE_LSB]))
                    == MEM_LOAD;

   //////////////////////////////////////////////////////////////////////////////
   // Writeback side
   //////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (result_load) begin
         out_bundle.instruction <= latched.instruction;
         out_bundle.incr_pc     <= latched.incr_pc;
         out_bundle.xcomp       <= latched.xcomp;
         out_bundle.read_data   <= is_load ? read_data : '0;
         out_bundle.reg_wrt     <= latched.reg_wrt;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         full <= 1'b0;
      end else if (result_load) begin
         full <= 1'b1;
      end else if (full && out_ready) begin
         full <= 1'b0;
      end
   end

   assign out_valid   = full;
   assign result_full = full;

endmodule

// File: mem_stage_top.sv
`timescale 1ns/1ns

module mem_stage_top import isa_pkg::*, pipe_pkg::*; #(
   parameter int ADDR_BITS   = 8,
   parameter int MEM_LATENCY = 3
) (
   input  logic       clk,
   input  logic       arst_n,
   input  xm_bundle_t in_bundle,
   input  logic       in_valid,
   output logic       in_ready,
   input  wb_write_t  wb_write,
   output mw_bundle_t out_bundle,
   output logic       out_valid,
   input  logic       out_ready
);

   // Control
   logic load_en;
   logic timer_start;
   logic timer_done;
   logic mem_en;
   logic mem_wr;
   logic result_load;
   logic result_full;

   // Data
   word_t      store_word;
   word_t      mem_rdata;
   xm_bundle_t latched;

   //////////////////////////////////////////////////////////////////////////////
   // Control path
   //////////////////////////////////////////////////////////////////////////////

   mem_ctrl_fsm mem_ctrl_fsm_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .in_valid    (in_valid),
      .out_ready   (out_ready),
      .in_opcode   (opcode_e'(in_bundle.instruction[OPCODE_MSB:OPCODE_LSB])),
      .timer_done  (timer_done),
      .result_full (result_full),
      .in_ready    (in_ready),
      .load_en     (load_en),
      .timer_start (timer_start),
      .mem_en      (mem_en),
      .mem_wr      (mem_wr),
      .result_load (result_load),
      .mem_op      ()
   );

   mem_wait_timer #(
      .MEM_LATENCY (MEM_LATENCY)
   ) mem_wait_timer_i (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (timer_start),
      .done   (timer_done)
   );

   //////////////////////////////////////////////////////////////////////////////
   // Data path
   //////////////////////////////////////////////////////////////////////////////

   store_fwd_unit store_fwd_unit_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .wb_write   (wb_write),
      .src_reg    (in_bundle.instruction[SRC_MSB:SRC_LSB]),
      .rf_data    (in_bundle.store_data),
      .store_word (store_word)
   );

   // Address is the low bits of the execute result
   data_mem #(
      .ADDR_BITS (ADDR_BITS)
   ) data_mem_i (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (mem_en),
      .wr     (mem_wr),
      .addr   (latched.xcomp[ADDR_BITS-1:0]),
      .wdata  (latched.store_data),
      .rdata  (mem_rdata)
   );

   mem_result_reg mem_result_reg_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .load_en     (load_en),
      .in_bundle   (in_bundle),
      .store_word  (store_word),
      .result_load (result_load),
      .read_data   (mem_rdata),
      .out_ready   (out_ready),
      .latched     (latched),
      .out_bundle  (out_bundle),
      .out_valid   (out_valid),
      .result_full (result_full)
   );

endmodule

// File: mem_stage_sva.sv
`timescale 1ns/1ns

module mem_stage_sva (
   input logic clk,
   input logic arst_n,
   input logic out_ready,
   input logic in_ready,
   input logic load_en,
   input logic timer_start,
   input logic mem_en,
   input logic mem_wr,
   input logic result_load,
   input logic result_full
);

   // Full result register is out_valid at the top level
   valid_held: assert property (@(posedge clk) disable iff (!arst_n)
      result_full && !out_ready |=> result_full)
      else $error("out_valid dropped while the output was stalled");

   wr_needs_en: assert property (@(posedge clk) disable iff (!arst_n)
      mem_wr |-> mem_en)
      else $error("memory write without memory enable");

   ready_valid_apart: assert property (@(posedge clk) disable iff (!arst_n)
      !(in_ready && result_full))
      else $error("in_ready and out_valid high together");

   quiet_in_reset: assert property (@(posedge clk)
      !arst_n |-> !in_ready && !load_en && !timer_start && !mem_en && !mem_wr && !result_load)
      else $error("control output active during reset");

endmodule

// File: tb_mem_stage.sv
`timescale 1ns/1ns

module tb_mem_stage import isa_pkg::*, pipe_pkg::*; ();

   localparam int ADDR_BITS   = 8;
   localparam int MEM_LATENCY = 3;
   // Longest run of random out_ready stalls
   localparam int MAX_STALL   = 4;

   typedef logic [71:0] chk_t;

   typedef struct packed {
      logic  is_wb;
      word_t instr;
      word_t pc;
      word_t xcomp;
      word_t sdata;
      logic  reg_wrt;
      logic  stall;
      word_t exp_read;
   } case_t;

   logic       clk;
   logic       arst_n;
   xm_bundle_t in_bundle;
   logic       in_valid;
   logic       in_ready;
   wb_write_t  wb_write;
   mw_bundle_t out_bundle;
   logic       out_valid;
   logic       out_ready;

   case_t      cases[$];
   word_t      mem_model [2**ADDR_BITS];
   logic       written [2**ADDR_BITS];
   wb_write_t  hist_new;
   wb_write_t  hist_old;
   int         cycle;
   int         limit;

   mem_stage_top #(
      .ADDR_BITS   (ADDR_BITS),
      .MEM_LATENCY (MEM_LATENCY)
   ) mem_stage_top_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_bundle  (in_bundle),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .wb_write   (wb_write),
      .out_bundle (out_bundle),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

   bind mem_ctrl_fsm mem_stage_sva mem_stage_sva_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .out_ready   (out_ready),
      .in_ready    (in_ready),
      .load_en     (load_en),
      .timer_start (timer_start),
      .mem_en      (mem_en),
      .mem_wr      (mem_wr),
      .result_load (result_load),
      .result_full (result_full)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (limit > 0 && cycle >= limit) begin
         $display("Timeout after %0d cycles, the stage stopped responding", cycle);
         $display("Something failed");
         $fatal(1, "timeout");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks and reference model
   ////////////////////////////////////////////////////////////////////////////

   task automatic fail_run(input string why);
      $display("ERROR: %s", why);
      $display("Something failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input chk_t actual, input chk_t expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         $display("Something failed");
         $fatal(1, "check failed");
      end
   endtask

   function automatic logic op_is_load(word_t instr);
      return instr[15:11] == 5'b10001;
   endfunction

   // ST and STU, SLBI shares the upper bits but is no store
   function automatic logic op_is_store(word_t instr);
      return (instr[15:11] == 5'b10000) || (instr[15:11] == 5'b10011);
   endfunction

   // Newest writeback write first, then the older one, then the register file
   function automatic word_t forward_word(reg_idx_t src, word_t rf);
      if (hist_new.valid && hist_new.rd == src) begin
         return hist_new.data;
      end else if (hist_old.valid && hist_old.rd == src) begin
         return hist_old.data;
      end
      return rf;
   endfunction

   task automatic read_cases();
      int               fd;
      int               n;
      logic [63:0]      tag;
      logic [8*120-1:0] rest;
      word_t            w_instr, w_pc, w_xc, w_sd, w_rw, w_st, w_exp;
      case_t            c;
      fd = $fopen("mem_cases.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open mem_cases.txt");
      end
      n = $fscanf(fd, "%s", tag);
      while (n == 1) begin
         if (tag == {56'h0, "#"}) begin
            n = $fgets(rest, fd);
         end else begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h",
                        w_instr, w_pc, w_xc, w_sd, w_rw, w_st, w_exp);
            if (n != 7) begin
               fail_run("malformed record in mem_cases.txt");
            end
            if (tag != {8'h0, "wbwrite"} && tag != {24'h0, "issue"}) begin
               fail_run("unknown record kind in mem_cases.txt");
            end
            c.is_wb    = (tag == {8'h0, "wbwrite"});
            c.instr    = w_instr;
            c.pc       = w_pc;
            c.xcomp    = w_xc;
            c.sdata    = w_sd;
            c.reg_wrt  = w_rw[0];
            c.stall    = w_st[0];
            c.exp_read = w_exp;
            cases.push_back(c);
         end
         n = $fscanf(fd, "%s", tag);
      end
      $fclose(fd);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   // One-cycle write pulse, rd in the instr column
   task automatic apply_wb_write(input case_t c);
      wb_write.valid = 1'b1;
      wb_write.rd    = c.instr[2:0];
      wb_write.data  = c.sdata;
      hist_old       = hist_new;
      hist_new       = wb_write;
      @(negedge clk);
      wb_write = '0;
   endtask

   task automatic run_issue(input case_t c);
      xm_bundle_t           b;
      mw_bundle_t           exp_b;
      mw_bundle_t           held;
      logic [ADDR_BITS-1:0] addr;
      logic [31:0]          rnd;
      int                   lat;
      int                   acc_cycle;
      int                   stall_run;
      logic                 seen;
      logic                 done;
      b.instruction = c.instr;
      b.incr_pc     = c.pc;
      b.xcomp       = c.xcomp;
      b.store_data  = c.sdata;
      b.reg_wrt     = c.reg_wrt;
      addr          = c.xcomp[ADDR_BITS-1:0];
      exp_b.instruction = c.instr;
      exp_b.incr_pc     = c.pc;
      exp_b.xcomp       = c.xcomp;
      exp_b.read_data   = '0;
      exp_b.reg_wrt     = c.reg_wrt;
      lat = 1;
      if (op_is_store(c.instr)) begin
         mem_model[addr] = forward_word(c.instr[7:5], c.sdata);
         written[addr]   = 1'b1;
         lat = MEM_LATENCY + 2;
      end else if (op_is_load(c.instr)) begin
         if (!written[addr]) begin
            fail_run("a case loads an address that was never stored");
         end
         exp_b.read_data = mem_model[addr];
         lat = MEM_LATENCY + 2;
      end
      check_value("read_data column of mem_cases.txt", chk_t'(c.exp_read),
                  chk_t'(exp_b.read_data));

      in_bundle = b;
      in_valid  = 1'b1;
      while (!in_ready) begin
         @(negedge clk);
      end
      // Accepted on the coming rising edge
      acc_cycle = cycle + 1;
      @(negedge clk);
      in_valid  = 1'b0;
      in_bundle = ~b;

      seen      = 1'b0;
      done      = 1'b0;
      stall_run = 0;
      while (!done) begin
         if (out_valid && !seen) begin
            check_value("out_valid latency", chk_t'(cycle - acc_cycle), chk_t'(lat));
            check_value("out_bundle.instruction", chk_t'(out_bundle.instruction),
                        chk_t'(exp_b.instruction));
            check_value("out_bundle.incr_pc", chk_t'(out_bundle.incr_pc),
                        chk_t'(exp_b.incr_pc));
            check_value("out_bundle.xcomp", chk_t'(out_bundle.xcomp), chk_t'(exp_b.xcomp));
            check_value("out_bundle.read_data", chk_t'(out_bundle.read_data),
                        chk_t'(exp_b.read_data));
            check_value("out_bundle.reg_wrt", chk_t'(out_bundle.reg_wrt),
                        chk_t'(exp_b.reg_wrt));
            held = out_bundle;
            seen = 1'b1;
         end else if (out_valid) begin
            check_value("out_bundle under stall", chk_t'(out_bundle), chk_t'(held));
         end
         rnd       = $urandom;
         out_ready = !c.stall || rnd[0] || (stall_run >= MAX_STALL);
         if (out_valid && !out_ready) begin
            stall_run++;
         end
         done = out_valid && out_ready;
         @(negedge clk);
      end
      // No second copy of the same result
      check_value("out_valid after handshake", chk_t'(out_valid), '0);
   endtask

   initial begin
      logic [31:0] seed_ret;
      seed_ret  = $urandom(76190);
      cycle     = 0;
      limit     = 0;
      arst_n    = 1'b0;
      in_bundle = '0;
      in_valid  = 1'b0;
      wb_write  = '0;
      out_ready = 1'b0;
      hist_new  = '0;
      hist_old  = '0;
      for (int i = 0; i < 2**ADDR_BITS; i++) begin
         written[i] = 1'b0;
      end
      read_cases();
      limit = cases.size() * (MEM_LATENCY + 2 + MAX_STALL) + 100;

      repeat (16) @(negedge clk);
      check_value("in_ready in reset", chk_t'(in_ready), '0);
      check_value("out_valid in reset", chk_t'(out_valid), '0);
      arst_n = 1'b1;
      @(negedge clk);
      check_value("in_ready after reset", chk_t'(in_ready), chk_t'(1'b1));
      check_value("out_valid after reset", chk_t'(out_valid), '0);

      foreach (cases[i]) begin
         if (cases[i].is_wb) begin
            apply_wb_write(cases[i]);
         end else begin
            run_issue(cases[i]);
         end
      end

      $display("Everything OK");
      $finish;
   end

endmodule

// File: mem_cases.txt
# kind instr incr_pc xcomp store_data reg_wrt stall exp_read, all hex
# wbwrite records carry rd in the instr column and the write data in store_data
issue   8020 0002 0010 1111 0 0 0000
issue   8800 0004 0010 0000 1 0 1111
issue   d825 0006 1234 0000 1 1 0000
wbwrite 0002 0000 0000 aaaa 0 0 0000
issue   8040 0008 0020 2222 0 1 0000
wbwrite 0003 0000 0000 bbbb 0 0 0000
issue   9840 000a 0021 3333 1 0 0000
wbwrite 0002 0000 0000 cccc 0 0 0000
issue   9840 000c 0022 4444 1 1 0000
issue   8060 000e 0023 5555 0 0 0000
issue   80a0 0010 0024 6666 0 1 0000
issue   8800 0012 0020 0000 1 1 aaaa
issue   8800 0014 0021 0000 1 0 aaaa
issue   8800 0016 0022 0000 1 1 cccc
issue   8800 0018 0023 0000 1 1 bbbb
issue   8800 001a 0024 0000 1 0 6666
issue   9020 001c 0010 7777 1 1 0000
issue   8800 001e 0110 0000 1 1 1111

// File: sources.f
isa_pkg.sv
pipe_pkg.sv
mem_ctrl_fsm.sv
mem_wait_timer.sv
store_fwd_unit.sv
data_mem.sv
mem_result_reg.sv
mem_stage_top.sv
mem_stage_sva.sv
tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_mem_stage -f sources.f
./obj_dir/Vtb_mem_stage | tee sim.log

if grep -q "Something failed" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi
if ! grep -q "Everything OK" sim.log; then
   echo "Simulation did not run to the end, see sim.log"
   exit 1
fi
echo "Simulation passed"
